// File: build.f
+incdir+.
stream_pkg.sv
streamer_regs.sv
stream_addr_gen.sv
stream_source.sv
tcdm_sram.sv
stream_source_top.sv
tb_stream_source.sv

// File: run.sh
#!/bin/sh
# compile and run the streamer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_stream_source -f build.f -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
else
  exit 1
fi

// File: tb_stream_source.sv
// testbench with clock and reset, scratchpad preload, pattern transfers, scoreboard and protocol checks
`default_nettype none
`include "stream_consts.svh"

module tb_stream_source;
  timeunit 1ns;
  timeprecision 1ps;
  import stream_pkg::*;

  localparam int N_TESTS    = 8;
  localparam int DONE_LIMIT = 4000; // cycles allowed per transfer

  typedef struct packed {
    pattern_cfg_t cfg;
    logic         rnd;  // random ready and stall
    logic         poke; // extra start write while busy
  } test_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  reg_we;
  logic [2:0]            reg_addr;
  logic [31:0]           reg_wdata;
  logic                  mem_stall;
  logic                  load_we;
  logic [`MEM_AW-1:0]    load_addr;
  logic [`STREAM_DW-1:0] load_data;
  beat_t                 out;
  logic                  out_ready;
  logic                  busy;
  logic                  done;

  logic [31:0] exp_q [$]; // expected beats in order
  logic [31:0] exp_data;
  test_t       tests [N_TESTS];
  logic        rand_mode;
  logic        started;   // first start write seen
  logic        timed_out;
  int          done_seen;
  int          beat_idx;
  int          err_data;
  int          err_hold;
  int          err_status;
  int          err_done;
  int          err_timeout;
  logic        prev_valid;
  logic        prev_ready;
  logic [31:0] prev_data;

  stream_source_top i_stream_source_top (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .reg_we_i    ( reg_we    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .mem_stall_i ( mem_stall ),
    .load_we_i   ( load_we   ),
    .load_addr_i ( load_addr ),
    .load_data_i ( load_data ),
    .out_o       ( out       ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      ),
    .done_o      ( done      )
  );

  always #50 clk_i = ~clk_i; // 100 ns period

  // byte model folding in every address bit
  function automatic logic [7:0] model_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  // four model bytes from a in little-endian order
  function automatic logic [31:0] model_word(input logic [31:0] a);
    return {model_byte(a + 32'd3), model_byte(a + 32'd2), model_byte(a + 32'd1), model_byte(a)};
  endfunction

  function automatic test_t make_test(input logic [31:0] base, input logic [15:0] wpl,
                                      input logic [31:0] stride, input logic [15:0] lines,
                                      input logic rnd, input logic poke);
    test_t t;
    t.cfg.base           = base;
    t.cfg.words_per_line = wpl;
    t.cfg.line_stride    = stride;
    t.cfg.lines          = lines;
    t.rnd                = rnd;
    t.poke               = poke;
    return t;
  endfunction

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    if (addr == 3'd4) begin
      started = 1'b1;
    end
    @(negedge clk_i);
    reg_we = 1'b0;
  endtask

  task automatic preload_memory();
    for (int w = 0; w < `MEM_WORDS; w++) begin
      logic [31:0] a;
      @(negedge clk_i);
      a         = 32'(w) << 2;
      load_we   = 1'b1;
      load_addr = a[`MEM_AW+1:2];
      load_data = model_word(a);
    end
    @(negedge clk_i);
    load_we = 1'b0;
  endtask

  // beat k sits at line k / wpl and word k mod wpl
  task automatic push_expected(input pattern_cfg_t cfg);
    int          total;
    int          line_idx;
    int          word_idx;
    logic [31:0] a;
    total = int'(cfg.words_per_line) * int'(cfg.lines);
    for (int k = 0; k < total; k++) begin
      line_idx = k / int'(cfg.words_per_line);
      word_idx = k % int'(cfg.words_per_line);
      a = cfg.base + 32'(line_idx) * cfg.line_stride + 32'(4 * word_idx);
      exp_q.push_back(model_word(a));
    end
  endtask

  task automatic run_transfer(input int idx, input test_t t);
    int cycles;
    rand_mode = t.rnd;
    write_reg(3'd0, t.cfg.base);
    write_reg(3'd1, {16'h0000, t.cfg.words_per_line});
    write_reg(3'd2, t.cfg.line_stride);
    write_reg(3'd3, {16'h0000, t.cfg.lines});
    push_expected(t.cfg);
    done_seen = 0;
    beat_idx  = 0;
    write_reg(3'd4, 32'd1);
    if (t.poke) begin
      repeat (3) @(negedge clk_i);
      assert (busy === 1'b1) else begin
        err_status++;
        $display("ERROR @ %0t: busy low early in transfer %0d", $time, idx);
      end
      write_reg(3'd1, 32'd1); // must not reach the pattern
      write_reg(3'd4, 32'd1); // must not restart
    end
    cycles = 0;
    while (done_seen == 0 && cycles < DONE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_seen == 0) begin
      err_timeout++;
      timed_out = 1'b1;
      $display("transfer %0d did not finish within %0d cycles", idx, DONE_LIMIT);
    end else begin
      repeat (8) @(negedge clk_i); // room for a second done or stray beats
      assert (done_seen == 1) else begin
        err_done++;
        $display("ERROR @ %0t: transfer %0d saw %0d done pulses", $time, idx, done_seen);
      end
      assert (exp_q.size() == 0) else begin
        err_data++;
        $display("ERROR @ %0t: transfer %0d left %0d beats", $time, idx, exp_q.size());
      end
    end
    rand_mode = 1'b0;
  endtask

  // sink and memory contention with new values each falling edge
  always @(negedge clk_i) begin
    if (rand_mode) begin
      out_ready = ($urandom % 4) != 0;
      mem_stall = ($urandom % 3) == 0;
    end else begin
      out_ready = 1'b1;
      mem_stall = 1'b0;
    end
  end

  // scoreboard and protocol checks on values from before the edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (!started) begin
        assert (!out.valid && !busy && !done) else begin
          err_status++;
          $display("ERROR @ %0t: valid %b busy %b done %b before start",
                   $time, out.valid, busy, done);
        end
      end
      if (prev_valid && !prev_ready) begin
        assert (out.valid && out.data == prev_data) else begin
          err_hold++;
          $display("ERROR @ %0t: stalled beat changed to %b %h, was %h",
                   $time, out.valid, out.data, prev_data);
        end
      end
      if (out.valid && out_ready) begin
        assert (exp_q.size() > 0) else begin
          err_data++;
          $display("ERROR @ %0t: beat %h with nothing expected", $time, out.data);
        end
        if (exp_q.size() > 0) begin
          exp_data = exp_q.pop_front();
          assert (out.data == exp_data) else begin
            err_data++;
            $display("ERROR @ %0t: beat %0d is %h, expected %h",
                     $time, beat_idx, out.data, exp_data);
          end
          beat_idx++;
        end
      end
      if (done) begin
        done_seen++;
        assert (exp_q.size() == 0 && !busy) else begin
          err_done++;
          $display("ERROR @ %0t: done with %0d beats open, busy %b", $time, exp_q.size(), busy);
        end
      end
      prev_valid = out.valid;
      prev_ready = out_ready;
      prev_data  = out.data;
    end
  end

  initial begin
    int err_total;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = 3'd0;
    reg_wdata   = 32'd0;
    mem_stall   = 1'b0;
    load_we     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    out_ready   = 1'b0;
    rand_mode   = 1'b0;
    started     = 1'b0;
    timed_out   = 1'b0;
    done_seen   = 0;
    beat_idx    = 0;
    err_data    = 0;
    err_hold    = 0;
    err_status  = 0;
    err_done    = 0;
    err_timeout = 0;
    prev_valid  = 1'b0;
    prev_ready  = 1'b0;
    prev_data   = 32'd0;
    void'($urandom(32'h445f_e0d6));

    tests[0] = make_test(32'h0000_0100, 16'd8,  32'h0000_0000, 16'd1, 1'b0, 1'b0); // aligned 1-D
    tests[1] = make_test(32'h0000_0201, 16'd5,  32'h0000_0000, 16'd1, 1'b0, 1'b0); // offset 1
    tests[2] = make_test(32'h0000_0302, 16'd6,  32'h0000_0000, 16'd1, 1'b0, 1'b0); // offset 2
    tests[3] = make_test(32'h0000_0403, 16'd7,  32'h0000_0000, 16'd1, 1'b0, 1'b0); // offset 3
    tests[4] = make_test(32'h0000_0500, 16'd4,  32'h0000_0040, 16'd5, 1'b0, 1'b0); // 2-D, gaps
    tests[5] = make_test(32'h0000_0613, 16'd3,  32'h0000_0024, 16'd6, 1'b1, 1'b0);
    tests[6] = make_test(32'h0000_0081, 16'd16, 32'h0000_0050, 16'd4, 1'b1, 1'b1);
    tests[7] = make_test(32'h0000_0900, 16'd40, 32'h0000_0000, 16'd1, 1'b1, 1'b0);

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    preload_memory();
    repeat (4) @(negedge clk_i);

    for (int i = 0; i < N_TESTS && !timed_out; i++) begin
      run_transfer(i, tests[i]);
    end

    err_total = err_data + err_hold + err_status + err_done + err_timeout;
    $display("errors: data %0d, hold %0d, status %0d, done %0d, timeout %0d",
             err_data, err_hold, err_status, err_done, err_timeout);
    if (err_total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: stream_source_top.sv
// top level: config registers, address generator, source streamer and scratchpad
`default_nettype none
`include "stream_consts.svh"

module stream_source_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_we_i,
  input  logic [2:0]            reg_addr_i,
  input  logic [31:0]           reg_wdata_i,
  input  logic                  mem_stall_i,
  input  logic                  load_we_i,
  input  logic [`MEM_AW-1:0]    load_addr_i,
  input  logic [`STREAM_DW-1:0] load_data_i,
  output stream_pkg::beat_t     out_o,
  input  logic                  out_ready_i,
  output logic                  busy_o,
  output logic                  done_o
);
  import stream_pkg::*;

  pattern_cfg_t   cfg;
  stream_status_t status; // busy, source done, generator done
  logic           start;
  byte_addr_u     addr;
  logic           addr_valid;
  logic           addr_take;
  mem_req_t       mem_req;
  mem_rsp_t       mem_rsp;

  assign busy_o = status.busy;

  streamer_regs i_streamer_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .src_done_i  ( status.done ),
    .cfg_o       ( cfg         ),
    .start_o     ( start       ),
    .busy_o      ( status.busy ),
    .done_o      ( done_o      )  // registered copy of source done
  );

  stream_addr_gen i_stream_addr_gen (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .start_i      ( start           ),
    .cfg_i        ( cfg             ),
    .addr_take_i  ( addr_take       ),
    .addr_o       ( addr            ),
    .addr_valid_o ( addr_valid      ),
    .gen_done_o   ( status.gen_done )
  );

  stream_source i_stream_source (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .start_i      ( start           ),
    .cfg_i        ( cfg             ),
    .addr_i       ( addr            ),
    .addr_valid_i ( addr_valid      ),
    .gen_done_i   ( status.gen_done ),
    .addr_take_o  ( addr_take       ),
    .mem_req_o    ( mem_req         ),
    .mem_rsp_i    ( mem_rsp         ),
    .out_o        ( out_o           ),
    .out_ready_i  ( out_ready_i     ),
    .done_o       ( status.done     )
  );

  tcdm_sram i_tcdm_sram (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .stall_i     ( mem_stall_i ),
    .load_we_i   ( load_we_i   ),
    .load_addr_i ( load_addr_i ),
    .load_data_i ( load_data_i ),
    .mem_req_i   ( mem_req     ),
    .mem_rsp_o   ( mem_rsp     )
  );

endmodule

`default_nettype wire

// File: tcdm_sram.sv
// word-banked scratchpad model with preload port, stall input and one-cycle 64-bit reads
`default_nettype none
`include "stream_consts.svh"

module tcdm_sram (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_i,
  input  logic                  load_we_i,
  input  logic [`MEM_AW-1:0]    load_addr_i,
  input  logic [`STREAM_DW-1:0] load_data_i,
  input  stream_pkg::mem_req_t  mem_req_i,
  output stream_pkg::mem_rsp_t  mem_rsp_o
);
  import stream_pkg::*;

  logic [`STREAM_DW-1:0] mem_q [`MEM_WORDS];
  byte_addr_u            req_addr;
  logic [`MEM_AW-1:0]    rd_idx;
  logic [`MEM_AW-1:0]    rd_idx_next;
  logic                  gnt;
  logic                  r_valid_q;
  logic [`MEM_DW-1:0]    r_data_q;

  assign req_addr.flat = mem_req_i.addr;
  assign rd_idx        = req_addr.split.word[`MEM_AW-1:0]; // word index, upper bits ignored
  assign rd_idx_next   = rd_idx + 1'b1;                    // wraps at the last word
  assign gnt           = mem_req_i.req && !stall_i;        // stall models contention

  // preload from outside
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  // two neighbouring words, lower address in low half
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= {mem_q[rd_idx_next], mem_q[rd_idx]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt; // one cycle after grant
    end
  end

  assign mem_rsp_o.gnt     = gnt;
  assign mem_rsp_o.r_valid = r_valid_q;
  assign mem_rsp_o.r_data  = r_data_q;

endmodule

`default_nettype wire

// File: stream_source.sv
// source streamer: FSM, memory requests, byte-offset FIFO, skid register, realignment, beat count
`default_nettype none
`include "stream_consts.svh"

module stream_source (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  stream_pkg::pattern_cfg_t cfg_i,
  input  stream_pkg::byte_addr_u   addr_i,
  input  logic                     addr_valid_i,
  input  logic                     gen_done_i,
  output logic                     addr_take_o,
  output stream_pkg::mem_req_t     mem_req_o,
  input  stream_pkg::mem_rsp_t     mem_rsp_i,
  output stream_pkg::beat_t        out_o,
  input  logic                     out_ready_i,
  output logic                     done_o
);
  import stream_pkg::*;

  localparam int unsigned OFS_PTR_W = $clog2(`OFS_FIFO_DEPTH);
  localparam int unsigned TOT_W     = 2 * `CNT_W;
  localparam logic [OFS_PTR_W-1:0] OFS_LAST = OFS_PTR_W'(`OFS_FIFO_DEPTH - 1);

  src_state_e state_q;
  src_state_e state_d;

  logic       req;
  logic       fire;
  byte_addr_u req_addr;

  logic [1:0]           ofs_mem_q [`OFS_FIFO_DEPTH];
  logic [OFS_PTR_W-1:0] ofs_wptr_q;
  logic [OFS_PTR_W-1:0] ofs_rptr_q;
  logic [OFS_PTR_W:0]   ofs_cnt_q;
  logic                 ofs_full;
  logic                 ofs_empty;
  logic [1:0]           ofs_head;

  logic               skid_valid_q;
  logic [`MEM_DW-1:0] skid_data_q;
  logic [`MEM_DW-1:0] rd_word;
  logic [`MEM_DW-1:0] rd_shifted;
  logic               beat_valid;
  logic               beat_fire;

  logic [TOT_W-1:0] beat_cnt_q;
  logic [TOT_W-1:0] beat_total;
  logic             cnt_clr;

  // only ask when returned data has a place to land
  assign req = (state_q != IDLE) && addr_valid_i && out_ready_i && !skid_valid_q && !ofs_full;

  always_comb begin
    req_addr             = addr_i;
    req_addr.split.offset = 2'b00; // word aligned to memory
  end

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = req_addr.flat;
  assign fire           = req && mem_rsp_i.gnt;
  assign addr_take_o    = fire; // generator steps next cycle

  // byte offset of every granted read
  assign ofs_full  = (ofs_cnt_q == `OFS_FIFO_DEPTH);
  assign ofs_empty = (ofs_cnt_q == '0);
  assign ofs_head  = ofs_mem_q[ofs_rptr_q];

  always_ff @(posedge clk_i) begin
    if (fire) begin
      ofs_mem_q[ofs_wptr_q] <= addr_i.split.offset;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_wptr_q <= '0;
      ofs_rptr_q <= '0;
      ofs_cnt_q  <= '0;
    end else begin
      if (fire) begin
        ofs_wptr_q <= (ofs_wptr_q == OFS_LAST) ? '0 : ofs_wptr_q + 1'b1;
      end
      if (beat_fire) begin
        ofs_rptr_q <= (ofs_rptr_q == OFS_LAST) ? '0 : ofs_rptr_q + 1'b1;
      end
      case ({fire, beat_fire})
        2'b10:   ofs_cnt_q <= ofs_cnt_q + 1'b1;
        2'b01:   ofs_cnt_q <= ofs_cnt_q - 1'b1;
        default: ; // both or none
      endcase
    end
  end

  // read data straight from memory, else parked copy
  assign beat_valid = mem_rsp_i.r_valid || skid_valid_q;
  assign beat_fire  = beat_valid && out_ready_i;
  assign rd_word    = mem_rsp_i.r_valid ? mem_rsp_i.r_data : skid_data_q;
  assign rd_shifted = rd_word >> {ofs_head, 3'b000}; // drop leading bytes

  assign out_o.valid = beat_valid;
  assign out_o.data  = rd_shifted[`STREAM_DW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (mem_rsp_i.r_valid && !out_ready_i) begin
      skid_valid_q <= 1'b1; // sink stalled, park the word
    end else if (skid_valid_q && out_ready_i) begin
      skid_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.r_valid && !out_ready_i) begin
      skid_data_q <= mem_rsp_i.r_data;
    end
  end

  assign beat_total = TOT_W'(cfg_i.words_per_line) * TOT_W'(cfg_i.lines);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (cnt_clr) begin
      beat_cnt_q <= '0;
    end else if (beat_fire) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    cnt_clr = 1'b0;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = WORKING;
          cnt_clr = 1'b1; // fresh count per transfer
        end
      end
      WORKING: begin
        if (gen_done_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if ((beat_cnt_q == beat_total) && ofs_empty) begin // no read in flight
          state_d = IDLE;
          done_o  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: stream_addr_gen.sv
// two-dimensional address generator, one byte address per taken request
`default_nettype none
`include "stream_consts.svh"

module stream_addr_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  stream_pkg::pattern_cfg_t cfg_i,
  input  logic                     addr_take_i,
  output stream_pkg::byte_addr_u   addr_o,
  output logic                     addr_valid_o,
  output logic                     gen_done_o
);
  import stream_pkg::*;

  logic              running_q;
  logic              done_q;
  logic [`CNT_W-1:0] word_cnt_q;
  logic [`CNT_W-1:0] line_cnt_q;
  byte_addr_u        addr_q;      // address on offer
  byte_addr_u        line_base_q; // start of current line
  byte_addr_u        next_line;
  logic              last_word;
  logic              last_line;
  logic              empty_pattern;
  logic              advance;

  assign empty_pattern = (cfg_i.words_per_line == '0) || (cfg_i.lines == '0);
  assign last_word     = (word_cnt_q == cfg_i.words_per_line - 1'b1);
  assign last_line     = (line_cnt_q == cfg_i.lines - 1'b1);
  assign advance       = running_q && addr_take_i;

  // stride added in whole words, byte lane of base kept
  always_comb begin
    next_line.split.word   = line_base_q.split.word + cfg_i.line_stride[`ADDR_W-1:2];
    next_line.split.offset = line_base_q.split.offset;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q  <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (start_i) begin
      running_q  <= !empty_pattern;
      done_q     <= empty_pattern; // nothing to walk
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (advance) begin
      if (!last_word) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end else if (!last_line) begin
        word_cnt_q <= '0;
        line_cnt_q <= line_cnt_q + 1'b1;
      end else begin
        running_q <= 1'b0; // last address gone
        done_q    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q.flat      <= cfg_i.base;
      line_base_q.flat <= cfg_i.base;
    end else if (advance) begin
      if (!last_word) begin
        addr_q.split.word <= addr_q.split.word + 1'b1; // next word, same lane
      end else begin
        addr_q      <= next_line;
        line_base_q <= next_line;
      end
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = running_q;
  assign gen_done_o   = done_q;

endmodule

`default_nettype wire

// File: streamer_regs.sv
// pattern registers on a write-strobe bus, start pulse, busy flag and done status pulse
`default_nettype none
`include "stream_consts.svh"

module streamer_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     reg_we_i,
  input  logic [2:0]               reg_addr_i,
  input  logic [31:0]              reg_wdata_i,
  input  logic                     src_done_i,
  output stream_pkg::pattern_cfg_t cfg_o,
  output logic                     start_o,
  output logic                     busy_o,
  output logic                     done_o
);
  import stream_pkg::*;

  localparam logic [2:0] REG_BASE   = 3'd0;
  localparam logic [2:0] REG_WPL    = 3'd1;
  localparam logic [2:0] REG_STRIDE = 3'd2;
  localparam logic [2:0] REG_LINES  = 3'd3;
  localparam logic [2:0] REG_START  = 3'd4;

  pattern_cfg_t cfg_q;
  logic         start_wr;
  logic         start_q;
  logic         busy_q;
  logic         done_q;

  assign start_wr = reg_we_i && (reg_addr_i == REG_START) && !busy_q; // dropped while busy

  // pattern fields, frozen while a transfer runs
  always_ff @(posedge clk_i) begin
    if (reg_we_i && !busy_q) begin
      case (reg_addr_i)
        REG_BASE:   cfg_q.base           <= reg_wdata_i;
        REG_WPL:    cfg_q.words_per_line <= reg_wdata_i[`CNT_W-1:0];
        REG_STRIDE: cfg_q.line_stride    <= reg_wdata_i;
        REG_LINES:  cfg_q.lines          <= reg_wdata_i[`CNT_W-1:0];
        default: ; // start and unused offsets
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= start_wr;   // single pulse
      done_q  <= src_done_i; // status pulse, one cycle late
      if (start_wr) begin
        busy_q <= 1'b1;
      end else if (src_done_i) begin
        busy_q <= 1'b0;      // drops together with done_o
      end
    end
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign done_o  = done_q;

endmodule

`default_nettype wire

// File: stream_pkg.sv
// shared types: pattern config, status, memory port, stream beat, address view, FSM states
`default_nettype none
`include "stream_consts.svh"

package stream_pkg;

  typedef struct packed {
    logic [`ADDR_W-1:0] base;           // first byte, may be misaligned
    logic [`CNT_W-1:0]  words_per_line; // 32-bit beats per line
    logic [`ADDR_W-1:0] line_stride;    // bytes between line starts
    logic [`CNT_W-1:0]  lines;          // number of lines
  } pattern_cfg_t;

  typedef struct packed {
    logic busy;     // transfer in progress
    logic done;     // end of transfer, one cycle
    logic gen_done; // last address taken
  } stream_status_t;

  typedef struct packed {
    logic               req;
    logic [`ADDR_W-1:0] addr; // always word aligned
  } mem_req_t;

  typedef struct packed {
    logic               gnt;
    logic               r_valid; // one cycle after gnt
    logic [`MEM_DW-1:0] r_data;  // word at addr in the low half
  } mem_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [`STREAM_DW-1:0] data;
  } beat_t;

  // byte address split into word index and byte lane
  typedef struct packed {
    logic [`ADDR_W-3:0] word;
    logic [1:0]         offset;
  } word_ofs_t;

  typedef union packed {
    logic [`ADDR_W-1:0] flat;  // plain byte address
    word_ofs_t          split; // word index and offset
  } byte_addr_u;

  typedef enum logic [1:0] {
    IDLE,    // waiting for start
    WORKING, // addresses still coming
    DRAIN    // generator done, last data in flight
  } src_state_e;

endpackage

`default_nettype wire

// File: stream_consts.svh
// width, depth and size macros of the 2-D read streamer
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// stream side
`define STREAM_DW 32 // output beat width

// memory side
`define MEM_DW 64 // one read returns two words
`define ADDR_W 32 // byte address width

// pattern counters, words per line and lines
`define CNT_W 16

// scratchpad size in 32-bit words
`define MEM_WORDS 1024

// word index width of the scratchpad, derived from its size
`define MEM_AW ($clog2(`MEM_WORDS))

// byte offsets kept between grant and read data
`define OFS_FIFO_DEPTH 4

`endif
